// ==== src/systolic_defines.svh ====
`ifndef SYSTOLIC_DEFINES_SVH
`define SYSTOLIC_DEFINES_SVH

// PE array geometry
`define PE_ROWS         8
`define PE_COLS         8
`define PE_ROWS_LOG2    3       // log2 of PE_ROWS
`define PE_COLS_LOG2    3       // log2 of PE_COLS

// Matrix sizes M, K and N, legal range 1 to 63
`define DIM_WIDTH       6

// Row address into operand and output SRAMs
`define SRAM_AWIDTH     8

// Step counter for compute and flush
// Longest compute is K + 2R - 1 = 78 cycles
`define STEP_WIDTH      7

`endif

// ==== src/systolic_pkg.sv ====
`include "systolic_defines.svh"

package systolic_pkg;

    // Matrix dimension M, K or N
    typedef logic [`DIM_WIDTH-1:0] dim_t;

    // Tile index or tile count, up to ceil(63/8) = 8
    typedef logic [`DIM_WIDTH-`PE_ROWS_LOG2:0] tile_id_t;

    // Active rows or columns in a tile, 1 to 8
    typedef logic [`PE_ROWS_LOG2:0] actv_t;

    typedef logic [`STEP_WIDTH-1:0] step_t;         // Compute or flush step

    typedef logic [`SRAM_AWIDTH-1:0] sram_addr_t;   // SRAM row address

    // One bit per row FIFO of operand 1
    typedef logic [`PE_ROWS-1:0] row_mask_t;

    // One bit per column FIFO of operand 2 or per output column
    typedef logic [`PE_COLS-1:0] col_mask_t;

endpackage

// ==== src/tile_ctrl_if.sv ====
`timescale 1ns/100ps

interface tile_ctrl_if;

    // Phase of the current tile
    logic computing;
    logic flushing;
    logic advance;                  // Low while stalled
    logic tile_start;               // First compute step of a tile

    // Position of the tile within the output matrix
    systolic_pkg::tile_id_t tile_row_id;
    systolic_pkg::tile_id_t tile_col_id;
    systolic_pkg::tile_id_t num_tile_rows;      // Also the operand 1 stride
    systolic_pkg::tile_id_t num_tile_cols;      // Operand 2 and output stride

    // Ragged edge handling
    systolic_pkg::actv_t actv_rows;
    systolic_pkg::actv_t actv_cols;

    systolic_pkg::dim_t  k_size;
    systolic_pkg::step_t step;

    modport ctrl (
        output computing, flushing, advance, tile_start,
        output tile_row_id, tile_col_id, num_tile_rows, num_tile_cols,
        output actv_rows, actv_cols, k_size, step
    );

    modport dp (
        input computing, flushing, advance, tile_start,
        input tile_row_id, tile_col_id, num_tile_rows, num_tile_cols,
        input actv_rows, actv_cols, k_size, step
    );

endinterface

// ==== src/matmul_tile_fsm.sv ====
`timescale 1ns/100ps
`include "systolic_defines.svh"

module matmul_tile_fsm (
    input  logic               CLK,
    input  logic               RSTn,
    input  logic               start,
    input  logic               stall,
    input  systolic_pkg::dim_t m_size,
    input  systolic_pkg::dim_t k_size,
    input  systolic_pkg::dim_t n_size,
    output logic               finished,
    tile_ctrl_if.ctrl          tcif
);

    // ceil(size / lanes)
    function automatic systolic_pkg::tile_id_t tiles_of(
        input systolic_pkg::dim_t size,
        input int unsigned        lanes_log2
    );
        logic [`DIM_WIDTH:0] padded;
        padded = {1'b0, size} + ((1 << lanes_log2) - 1);
        return systolic_pkg::tile_id_t'(padded >> lanes_log2);
    endfunction

    // min(lanes, size - id * lanes)
    function automatic systolic_pkg::actv_t actv_of(
        input systolic_pkg::dim_t     size,
        input systolic_pkg::tile_id_t id,
        input int unsigned            lanes_log2
    );
        logic [`DIM_WIDTH:0] covered;
        logic [`DIM_WIDTH:0] remain;
        covered = id;
        covered = covered << lanes_log2;
        remain  = {1'b0, size} - covered;
        if (remain >= (1 << lanes_log2))
            return systolic_pkg::actv_t'(1 << lanes_log2);
        return systolic_pkg::actv_t'(remain);
    endfunction

    logic is_idle;
    logic is_computing;
    logic is_flushing;

    // Job sizes, held for the whole job
    systolic_pkg::dim_t m_lat;
    systolic_pkg::dim_t k_lat;
    systolic_pkg::dim_t n_lat;

    systolic_pkg::tile_id_t num_tr;
    systolic_pkg::tile_id_t num_tc;
    systolic_pkg::tile_id_t tr;
    systolic_pkg::tile_id_t tc;
    systolic_pkg::tile_id_t tr_nxt;
    systolic_pkg::tile_id_t tc_nxt;
    systolic_pkg::actv_t    ar;
    systolic_pkg::actv_t    ac;
    systolic_pkg::actv_t    ar_nxt;
    systolic_pkg::actv_t    ac_nxt;
    systolic_pkg::step_t    step;
    systolic_pkg::step_t    compute_last;

    logic col_wrap;
    logic last_tile;
    logic compute_done;
    logic flush_done;
    logic launch;
    logic next_tile;

    // Row-major walk, column tile is the inner loop
    assign col_wrap = (tc == num_tc - 1'b1);
    assign tc_nxt   = (is_idle || col_wrap) ? '0 : tc + 1'b1;
    assign tr_nxt   = is_idle ? '0 : (col_wrap ? tr + 1'b1 : tr);
    assign ar_nxt   = actv_of(is_idle ? m_size : m_lat, tr_nxt, `PE_ROWS_LOG2);
    assign ac_nxt   = actv_of(is_idle ? n_size : n_lat, tc_nxt, `PE_COLS_LOG2);

    // Last compute step is K + ar + ac - 2
    assign compute_last = systolic_pkg::step_t'(k_lat) + systolic_pkg::step_t'(ar)
                        + systolic_pkg::step_t'(ac) - systolic_pkg::step_t'(2);
    assign compute_done = is_computing & (step == compute_last);
    assign flush_done   = is_flushing & (step == systolic_pkg::step_t'(`PE_ROWS - 1));
    assign last_tile    = (tr == num_tr - 1'b1) & col_wrap;

    assign launch    = is_idle & start;              // START ignored outside idle
    assign next_tile = flush_done & ~last_tile;
    assign finished  = flush_done & last_tile;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            is_idle      <= 1'b1;
            is_computing <= 1'b0;
            is_flushing  <= 1'b0;
            num_tr       <= '0;
            num_tc       <= '0;
            tr           <= '0;
            tc           <= '0;
            ar           <= '0;
            ac           <= '0;
            step         <= '0;
        end else if (!stall) begin
            if (launch) begin
                num_tr <= tiles_of(m_size, `PE_ROWS_LOG2);
                num_tc <= tiles_of(n_size, `PE_COLS_LOG2);
            end
            if (launch || next_tile) begin
                tr           <= tr_nxt;
                tc           <= tc_nxt;
                ar           <= ar_nxt;
                ac           <= ac_nxt;
                is_idle      <= 1'b0;
                is_computing <= 1'b1;
                is_flushing  <= 1'b0;
                step         <= '0;
            end else if (compute_done) begin
                is_computing <= 1'b0;
                is_flushing  <= 1'b1;
                step         <= '0;
            end else if (flush_done) begin
                // Final tile drained, back to idle
                is_flushing <= 1'b0;
                is_idle     <= 1'b1;
                step        <= '0;
            end else if (!is_idle) begin
                step <= step + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall && launch) begin
            m_lat <= m_size;
            k_lat <= k_size;
            n_lat <= n_size;
        end
    end

    assign tcif.computing     = is_computing;
    assign tcif.flushing      = is_flushing;
    assign tcif.advance       = ~stall;
    assign tcif.tile_start    = is_computing & (step == '0);
    assign tcif.tile_row_id   = tr;
    assign tcif.tile_col_id   = tc;
    assign tcif.num_tile_rows = num_tr;
    assign tcif.num_tile_cols = num_tc;
    assign tcif.actv_rows     = ar;
    assign tcif.actv_cols     = ac;
    assign tcif.k_size        = k_lat;
    assign tcif.step          = step;

endmodule

// ==== src/operand_addr_gen.sv ====
`timescale 1ns/100ps

module operand_addr_gen (
    input  logic                     CLK,
    input  logic                     RSTn,
    tile_ctrl_if.dp                  tcif,
    output systolic_pkg::sram_addr_t opnd1_sram_addr,
    output systolic_pkg::sram_addr_t opnd2_sram_addr
);

    systolic_pkg::sram_addr_t opnd1_acc;
    systolic_pkg::sram_addr_t opnd2_acc;
    systolic_pkg::sram_addr_t opnd1_stride;
    systolic_pkg::sram_addr_t opnd2_stride;

    // Operand 1 is column-major, one step of K is TR rows apart
    assign opnd1_stride = systolic_pkg::sram_addr_t'(tcif.num_tile_rows);
    // Operand 2 is row-major, one step of K is TC rows apart
    assign opnd2_stride = systolic_pkg::sram_addr_t'(tcif.num_tile_cols);

    // Tile base on step 0, walked address afterwards
    assign opnd1_sram_addr = tcif.tile_start ?
                             systolic_pkg::sram_addr_t'(tcif.tile_row_id) : opnd1_acc;
    assign opnd2_sram_addr = tcif.tile_start ?
                             systolic_pkg::sram_addr_t'(tcif.tile_col_id) : opnd2_acc;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            opnd1_acc <= '0;
            opnd2_acc <= '0;
        end else if (tcif.advance && tcif.computing) begin
            opnd1_acc <= opnd1_sram_addr + opnd1_stride;
            opnd2_acc <= opnd2_sram_addr + opnd2_stride;   // Wraps past 255
        end
    end

endmodule

// ==== src/fifo_enable_gen.sv ====
`timescale 1ns/100ps
`include "systolic_defines.svh"

module fifo_enable_gen (
    tile_ctrl_if.dp                 tcif,
    output systolic_pkg::row_mask_t opnd1_push_en,
    output systolic_pkg::row_mask_t opnd1_pop_en,
    output systolic_pkg::col_mask_t opnd2_push_en,
    output systolic_pkg::col_mask_t opnd2_pop_en
);

    // FIFO lane idx pops while idx <= step <= K - 1 + idx
    function automatic logic pop_window(
        input systolic_pkg::step_t step,
        input systolic_pkg::step_t k_steps,
        input int unsigned         idx
    );
        systolic_pkg::step_t lane;
        lane = systolic_pkg::step_t'(idx);
        return (step >= lane) && (step < k_steps + lane);
    endfunction

    systolic_pkg::step_t k_steps;
    logic                push_window;

    assign k_steps = systolic_pkg::step_t'(tcif.k_size);

    // All FIFOs fill together during the first K steps
    assign push_window   = tcif.computing & (tcif.step < k_steps);
    assign opnd1_push_en = {`PE_ROWS{push_window}};
    assign opnd2_push_en = {`PE_COLS{push_window}};

    // Pops skewed by one step per lane for the diagonal wavefront
    always_comb begin
        for (int i = 0; i < `PE_ROWS; i++) begin
            opnd1_pop_en[i] = tcif.computing & pop_window(tcif.step, k_steps, i);
        end
        for (int j = 0; j < `PE_COLS; j++) begin
            opnd2_pop_en[j] = tcif.computing & pop_window(tcif.step, k_steps, j);
        end
    end

endmodule

// ==== src/result_write_gen.sv ====
`timescale 1ns/100ps
`include "systolic_defines.svh"

module result_write_gen (
    input  logic                     CLK,
    input  logic                     RSTn,
    tile_ctrl_if.dp                  tcif,
    output systolic_pkg::sram_addr_t out_sram_addr,
    output logic                     out_sram_we,
    output systolic_pkg::col_mask_t  out_col_en
);

    systolic_pkg::sram_addr_t row_offset;     // tr * R * TC
    systolic_pkg::sram_addr_t row_stride;
    systolic_pkg::sram_addr_t col_stride;
    systolic_pkg::sram_addr_t addr_acc;
    systolic_pkg::step_t      first_wr_step;
    logic                     flush_first;

    // One row tile spans R output rows of TC words each
    assign row_stride = systolic_pkg::sram_addr_t'(tcif.num_tile_cols) << `PE_ROWS_LOG2;
    assign col_stride = systolic_pkg::sram_addr_t'(tcif.num_tile_cols);

    assign flush_first   = tcif.flushing & (tcif.step == '0);
    assign out_sram_addr = flush_first ?
                           row_offset + systolic_pkg::sram_addr_t'(tcif.tile_col_id) :
                           addr_acc;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            row_offset <= '0;
            addr_acc   <= '0;
        end else if (tcif.advance) begin
            // Row tile changes only when the column tile wraps to 0
            if (tcif.tile_start && tcif.tile_col_id == '0) begin
                row_offset <= (tcif.tile_row_id == '0) ? '0 : row_offset + row_stride;
            end
            if (tcif.flushing) begin
                addr_acc <= out_sram_addr + col_stride;
            end
        end
    end

    // Accumulator rows leave bottom first, so idle rows come out early
    assign first_wr_step = systolic_pkg::step_t'(`PE_ROWS)
                         - systolic_pkg::step_t'(tcif.actv_rows);
    assign out_sram_we   = tcif.flushing & (tcif.step >= first_wr_step);

    always_comb begin
        for (int j = 0; j < `PE_COLS; j++) begin
            out_col_en[j] = tcif.flushing & (systolic_pkg::actv_t'(j) < tcif.actv_cols);
        end
    end

endmodule

// ==== src/systolic_ctrl_top.sv ====
`timescale 1ns/100ps

module systolic_ctrl_top (
    input  logic                     CLK,
    input  logic                     RSTn,
    input  logic                     start,
    input  logic                     stall,
    input  systolic_pkg::dim_t       m_size,
    input  systolic_pkg::dim_t       k_size,
    input  systolic_pkg::dim_t       n_size,

    // Operand SRAM read rows
    output systolic_pkg::sram_addr_t opnd1_sram_addr,
    output systolic_pkg::sram_addr_t opnd2_sram_addr,

    // Operand FIFO enables
    output systolic_pkg::row_mask_t  opnd1_push_en,
    output systolic_pkg::row_mask_t  opnd1_pop_en,
    output systolic_pkg::col_mask_t  opnd2_push_en,
    output systolic_pkg::col_mask_t  opnd2_pop_en,

    // Result write port
    output systolic_pkg::sram_addr_t out_sram_addr,
    output logic                     out_sram_we,
    output systolic_pkg::col_mask_t  out_col_en,

    output logic                     computing,
    output logic                     flushing,
    output logic                     finished
);

    tile_ctrl_if tcif ();

    matmul_tile_fsm u_fsm (
        .CLK      (CLK),
        .RSTn     (RSTn),
        .start    (start),
        .stall    (stall),
        .m_size   (m_size),
        .k_size   (k_size),
        .n_size   (n_size),
        .finished (finished),
        .tcif     (tcif.ctrl)
    );

    operand_addr_gen u_opnd_addr (
        .CLK             (CLK),
        .RSTn            (RSTn),
        .tcif            (tcif.dp),
        .opnd1_sram_addr (opnd1_sram_addr),
        .opnd2_sram_addr (opnd2_sram_addr)
    );

    fifo_enable_gen u_fifo_en (
        .tcif          (tcif.dp),
        .opnd1_push_en (opnd1_push_en),
        .opnd1_pop_en  (opnd1_pop_en),
        .opnd2_push_en (opnd2_push_en),
        .opnd2_pop_en  (opnd2_pop_en)
    );

    result_write_gen u_result_wr (
        .CLK           (CLK),
        .RSTn          (RSTn),
        .tcif          (tcif.dp),
        .out_sram_addr (out_sram_addr),
        .out_sram_we   (out_sram_we),
        .out_col_en    (out_col_en)
    );

    // PE array mode strobes
    assign computing = tcif.computing;
    assign flushing  = tcif.flushing;

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic CLK,
    output logic RSTn
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    // Synchronous reset, released just after a rising edge
    initial begin
        RSTn = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2 RSTn = 1'b1;
    end

endmodule

// ==== sim/systolic_ctrl_tb.sv ====
`timescale 1ns/100ps
`include "systolic_defines.svh"

module systolic_ctrl_tb;

    localparam int R = `PE_ROWS;
    localparam int C = `PE_COLS;
    localparam int PH_IDLE  = 0;
    localparam int PH_COMP  = 1;
    localparam int PH_FLUSH = 2;
    // A random job has at most 64 tiles of (63 + R + C - 1 + R) = 86 cycles
    // Three of them need about 16500 cycles and the directed jobs stay under 1000
    localparam int CYCLE_LIMIT = 20000;

    logic                     CLK;
    logic                     RSTn;
    logic                     start;
    logic                     stall;
    systolic_pkg::dim_t       m_size;
    systolic_pkg::dim_t       k_size;
    systolic_pkg::dim_t       n_size;
    systolic_pkg::sram_addr_t opnd1_sram_addr;
    systolic_pkg::sram_addr_t opnd2_sram_addr;
    systolic_pkg::row_mask_t  opnd1_push_en;
    systolic_pkg::row_mask_t  opnd1_pop_en;
    systolic_pkg::col_mask_t  opnd2_push_en;
    systolic_pkg::col_mask_t  opnd2_pop_en;
    systolic_pkg::sram_addr_t out_sram_addr;
    logic                     out_sram_we;
    systolic_pkg::col_mask_t  out_col_en;
    logic                     computing;
    logic                     flushing;
    logic                     finished;

    // Reference model state
    int mdl_phase;
    int mdl_tr;
    int mdl_tc;
    int mdl_step;
    int mdl_m;
    int mdl_k;
    int mdl_n;

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int fin_seen;                       // Finished pulses in the current job
    int comp_seen;                      // Unstalled compute cycles in the current job
    int cycle_cnt    = 0;
    int seed;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(2)) clk_gen_i (.CLK(CLK), .RSTn(RSTn));

    systolic_ctrl_top dut_i (.*);

    always @(posedge CLK) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic int tile_count(input int size, input int lanes);
        return (size + lanes - 1) / lanes;
    endfunction

    // Rows or columns of the tile that hold real data
    function automatic int active_lanes(input int size, input int id, input int lanes);
        int rem;
        rem = size - id * lanes;
        return (rem > lanes) ? lanes : rem;
    endfunction

    task automatic compare_word(input string test, input string sig,
                                input logic [31:0] expv, input logic [31:0] actv);
        assert (actv === expv) else begin
            $display("Mismatch in %s on %s: expected %0h, actual %0h", test, sig, expv, actv);
            errors++;
        end
    endtask

    task automatic check_outputs(input string test);
        int   ar;
        int   ac;
        int   num_tr;
        int   num_tc;
        int   push_r;
        int   push_c;
        int   pop_r;
        int   pop_c;
        logic in_comp;
        logic in_flush;
        logic exp_fin;
        in_comp  = (mdl_phase == PH_COMP);
        in_flush = (mdl_phase == PH_FLUSH);
        ar       = active_lanes(mdl_m, mdl_tr, R);
        ac       = active_lanes(mdl_n, mdl_tc, C);
        num_tr   = tile_count(mdl_m, R);
        num_tc   = tile_count(mdl_n, C);
        exp_fin  = in_flush && mdl_step == R - 1 && mdl_tr == num_tr - 1 && mdl_tc == num_tc - 1;
        push_r   = (in_comp && mdl_step < mdl_k) ? (1 << R) - 1 : 0;
        push_c   = (in_comp && mdl_step < mdl_k) ? (1 << C) - 1 : 0;
        pop_r    = 0;
        pop_c    = 0;
        for (int i = 0; i < R; i++) begin
            if (in_comp && mdl_step >= i && mdl_step <= mdl_k - 1 + i) pop_r |= 1 << i;
        end
        for (int j = 0; j < C; j++) begin
            if (in_comp && mdl_step >= j && mdl_step <= mdl_k - 1 + j) pop_c |= 1 << j;
        end

        assert (computing === in_comp && flushing === in_flush) else begin
            $display("%s: phase change missed at tile (%0d,%0d) step %0d, %s %b %s %b",
                     test, mdl_tr, mdl_tc, mdl_step,
                     "DUT computing", computing, "flushing", flushing);
            errors++;
        end
        assert (finished === exp_fin) else begin
            $display("%s: finished pulse %s at tile (%0d,%0d) step %0d", test,
                     exp_fin ? "missing" : "raised out of place", mdl_tr, mdl_tc, mdl_step);
            errors++;
        end

        compare_word(test, "opnd1_push_en", push_r, opnd1_push_en);
        compare_word(test, "opnd2_push_en", push_c, opnd2_push_en);
        compare_word(test, "opnd1_pop_en", pop_r, opnd1_pop_en);
        compare_word(test, "opnd2_pop_en", pop_c, opnd2_pop_en);
        if (in_comp) begin
            compare_word(test, "opnd1_sram_addr", (mdl_tr + mdl_step * num_tr) % 256,
                         opnd1_sram_addr);
            compare_word(test, "opnd2_sram_addr", (mdl_tc + mdl_step * num_tc) % 256,
                         opnd2_sram_addr);
        end
        if (in_flush) begin
            compare_word(test, "out_sram_addr",
                         (mdl_tr * R * num_tc + mdl_tc + mdl_step * num_tc) % 256,
                         out_sram_addr);
        end
        compare_word(test, "out_sram_we", in_flush && mdl_step >= R - ar, out_sram_we);
        compare_word(test, "out_col_en", in_flush ? (1 << ac) - 1 : 0, out_col_en);
    endtask

    // Moves the model one unstalled cycle on
    task automatic advance_model(input logic st);
        int ar;
        int ac;
        ar = active_lanes(mdl_m, mdl_tr, R);
        ac = active_lanes(mdl_n, mdl_tc, C);
        case (mdl_phase)
            PH_IDLE: begin
                if (st) begin
                    mdl_m     = m_size;
                    mdl_k     = k_size;
                    mdl_n     = n_size;
                    mdl_tr    = 0;
                    mdl_tc    = 0;
                    mdl_step  = 0;
                    mdl_phase = PH_COMP;
                end
            end
            PH_COMP: begin
                if (mdl_step == mdl_k + ar + ac - 2) begin
                    mdl_phase = PH_FLUSH;
                    mdl_step  = 0;
                end else begin
                    mdl_step++;
                end
            end
            default: begin
                if (mdl_step != R - 1) begin
                    mdl_step++;
                end else if (mdl_tc == tile_count(mdl_n, C) - 1 &&
                             mdl_tr == tile_count(mdl_m, R) - 1) begin
                    mdl_phase = PH_IDLE;
                end else begin
                    mdl_phase = PH_COMP;
                    mdl_step  = 0;
                    if (mdl_tc == tile_count(mdl_n, C) - 1) begin   // Column tile is inner loop
                        mdl_tc = 0;
                        mdl_tr++;
                    end else begin
                        mdl_tc++;
                    end
                end
            end
        endcase
    endtask

    // Inputs change 2 ns after the rising edge and outputs are checked at the falling edge
    task automatic drive_cycle(input string test, input logic st, input logic stl);
        start = st;
        stall = stl;
        @(negedge CLK);
        check_outputs(test);
        if (!stl) begin
            if (finished) fin_seen++;
            if (computing) comp_seen++;
            advance_model(st);
        end
        @(posedge CLK);
        #2;
    endtask

    task automatic run_job(input string test, input int m, input int k, input int n,
                           input int stall_len, input bit mid_start);
        bit comp_stalled;
        bit flush_stalled;
        bit pulse;
        comp_stalled  = 1'b0;
        flush_stalled = 1'b0;
        fin_seen      = 0;
        comp_seen     = 0;
        m_size = systolic_pkg::dim_t'(m);
        k_size = systolic_pkg::dim_t'(k);
        n_size = systolic_pkg::dim_t'(n);
        if (stall_len > 0) drive_cycle(test, 1'b1, 1'b1);     // START under stall is lost
        drive_cycle(test, 1'b1, 1'b0);
        while (mdl_phase != PH_IDLE) begin
            if (stall_len > 0 && mdl_tr == 0 && mdl_tc == 0) begin
                if (!comp_stalled && mdl_phase == PH_COMP && mdl_step == 4) begin
                    repeat (stall_len) drive_cycle(test, 1'b0, 1'b1);
                    comp_stalled = 1'b1;
                end
                if (!flush_stalled && mdl_phase == PH_FLUSH && mdl_step == 3) begin
                    repeat (stall_len) drive_cycle(test, 1'b0, 1'b1);
                    flush_stalled = 1'b1;
                end
            end
            pulse = mid_start && ((mdl_phase == PH_COMP && mdl_step == 2) ||
                                  (mdl_phase == PH_FLUSH && mdl_step == 1));
            if (pulse) begin
                m_size = '1;    // Bogus sizes that must not reach the job
                k_size = '1;
                n_size = '1;
            end
            drive_cycle(test, pulse, 1'b0);
            m_size = systolic_pkg::dim_t'(m);
            k_size = systolic_pkg::dim_t'(k);
            n_size = systolic_pkg::dim_t'(n);
        end
        drive_cycle(test, 1'b0, 1'b0);
        assert (fin_seen == 1) else begin
            $display("%s: expected one finished pulse for the job, saw %0d", test, fin_seen);
            errors++;
        end
    endtask

    task automatic report_test(input string test, input int err_before, input string note);
        tests_run++;
        if (errors > err_before) begin
            tests_failed++;
            $display("%s: FAILED with %0d errors%s", test, errors - err_before, note);
        end else begin
            $display("%s: ok%s", test, note);
        end
    endtask

    task automatic reset_and_single_tile();
        int err_before;
        err_before = errors;
        repeat (2) drive_cycle("reset_single_tile", 1'b0, 1'b0);    // Idle after reset
        run_job("reset_single_tile", 8, 5, 8, 0, 1'b0);
        compare_word("reset_single_tile", "compute cycles", 5 + R + C - 1, comp_seen);
        report_test("reset_single_tile", err_before, "");
    endtask

    task automatic ragged_tile_job();
        int err_before;
        err_before = errors;
        run_job("ragged_tiles", 20, 3, 13, 0, 1'b0);
        report_test("ragged_tiles", err_before, "");
    endtask

    task automatic finish_and_restart();
        int err_before;
        err_before = errors;
        run_job("finish_and_restart", 12, 7, 17, 0, 1'b1);
        repeat (3) drive_cycle("finish_and_restart", 1'b0, 1'b0);
        report_test("finish_and_restart", err_before, "");
    endtask

    task automatic stall_freeze();
        int err_before;
        err_before = errors;
        run_job("stall_freeze", 9, 6, 10, 5, 1'b0);
        report_test("stall_freeze", err_before, "");
    endtask

    task automatic random_size_jobs();
        int    err_before;
        int    m;
        int    k;
        int    n;
        string sizes;
        err_before = errors;
        sizes      = " for";
        for (int job = 0; job < 3; job++) begin
            m = 1 + ({$random(seed)} % 63);
            k = 1 + ({$random(seed)} % 63);
            n = 1 + ({$random(seed)} % 63);
            sizes = {sizes, $sformatf(" %0dx%0dx%0d", m, k, n)};
            run_job("random_sizes", m, k, n, 0, 1'b0);
        end
        report_test("random_sizes", err_before, sizes);
    endtask

    initial begin
        start     = 1'b0;
        stall     = 1'b0;
        m_size    = '0;
        k_size    = '0;
        n_size    = '0;
        seed      = 32'h4429d35a;
        mdl_phase = PH_IDLE;
        mdl_tr    = 0;
        mdl_tc    = 0;
        mdl_step  = 0;
        mdl_m     = 0;
        mdl_k     = 0;
        mdl_n     = 0;
        @(posedge RSTn);

        reset_and_single_tile();
        ragged_tile_job();
        finish_and_restart();
        stall_freeze();
        random_size_jobs();

        $display("Tests run %0d, failed %0d, check errors %0d, cycles %0d",
                 tests_run, tests_failed, errors, cycle_cnt);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+src
src/systolic_pkg.sv
src/tile_ctrl_if.sv
src/matmul_tile_fsm.sv
src/operand_addr_gen.sv
src/fifo_enable_gen.sv
src/result_write_gen.sv
src/systolic_ctrl_top.sv
sim/tb_clock_gen.sv
sim/systolic_ctrl_tb.sv
